// ==== tb/splitter_trace.txt ====
# C offset data resp | R offset data | A id addr len size burst | P addr len
# All fields hex; P lines are the expected downstream pieces of the A line above
# Register access, only the low byte is kept
C 0 1A5 0
R 0 A5
C 4 3 2
R 4 0
R 0 A5
# Passthrough at limit 3
C 0 3 0
R 0 3
A 1 1000 2 2 1
P 1000 2
# INCR split from an unaligned start
R 0 3
A 2 2006 9 2 1
P 2006 3
P 2014 3
P 2024 1
# FIXED burst in single-beat mode
C 0 0 0
A 3 3008 4 2 0
P 3008 0
P 3008 0
P 3008 0
P 3008 0
P 3008 0
# Four bursts in flight
C 0 3 0
A 4 4000 7 2 1
P 4000 3
P 4010 3
A 5 5001 4 0 1
P 5001 3
P 5005 0
A 6 6002 6 1 1
P 6002 3
P 600A 2
A 7 7004 5 2 0
P 7004 3
P 7004 1
R 0 3

// ==== project.f ====
+incdir+common
common/axi_rd_pkg.sv
common/cfg_lite_pkg.sv
source/axi_burst_cfg_regs.sv
splitter/ar_burst_splitter.sv
splitter/read_last_restore.sv
source/axi_burst_splitter_top.sv
tb/splitter_asserts.sv
tb/tb_axi_burst_splitter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_axi_burst_splitter
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_axi_burst_splitter.sv ====
`timescale 1ns/1ps
`include "axi_burst_cfg.svh"

module tb_axi_burst_splitter
  import axi_rd_pkg::*;
  import cfg_lite_pkg::*;
();

  localparam string TRACE_FILE = "tb/splitter_trace.txt";
  localparam int unsigned WAIT_LIMIT = 100;
  localparam int unsigned GROUP_LIMIT = 4000;
  localparam logic [31:0] SEED = 32'h604cd413;
  localparam resp_t AXI_OKAY = 2'b00;

  // Expected downstream piece and the request it belongs to
  typedef struct packed {
    addr_t addr;
    len_t len;
    logic [7:0] req;
  } piece_t;

  logic clk_i;
  logic arst_n_i;
  lite_req_t cfg_req_i;
  lite_rsp_t cfg_rsp_o;
  ar_chan_t s_ar_i;
  logic s_ar_valid_i;
  logic s_ar_ready_o;
  r_chan_t s_r_o;
  logic s_r_valid_o;
  logic s_r_ready_i;
  ar_chan_t m_ar_o;
  logic m_ar_valid_o;
  logic m_ar_ready_i;
  r_chan_t m_r_i;
  logic m_r_valid_i;
  logic m_r_ready_o;

  ar_chan_t req_q[$];
  piece_t exp_q[$];
  ar_chan_t dn_q[$];
  ar_chan_t up_q[$];
  int unsigned error_count;

  axi_burst_splitter_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // -------------------------------------------------------------------
  // Reporting
  // -------------------------------------------------------------------
  task automatic end_with_failure();
    error_count++;
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      end_with_failure();
    end
  endtask

  task automatic check_timeout(input int unsigned cycles, input int unsigned limit,
                               input string what);
    assert (cycles < limit) else begin
      $display("Timeout while waiting for %s", what);
      end_with_failure();
    end
  endtask

  function automatic logic random_active();
    return ($urandom % 4) != 0;
  endfunction

  // Byte address of a beat
  // The first beat keeps an unaligned start
  function automatic data_t beat_address(input ar_chan_t ar, input int unsigned idx);
    addr_t aligned;
    aligned = ar.addr & ~((addr_t'(1) << ar.size) - addr_t'(1));
    if (ar.burst == BURST_FIXED || idx == 0) begin
      return data_t'(ar.addr);
    end
    return data_t'(aligned + (addr_t'(idx) << ar.size));
  endfunction

  // -------------------------------------------------------------------
  // Configuration port
  // -------------------------------------------------------------------
  task automatic cfg_write(input lite_addr_t offset, input lite_data_t data,
                           input lite_resp_t exp_resp);
    int unsigned cycles;
    cycles = 0;
    cfg_req_i.aw_valid <= 1'b1;
    cfg_req_i.aw_addr <= offset;
    cfg_req_i.w_valid <= 1'b1;
    cfg_req_i.w_data <= data;
    cfg_req_i.b_ready <= 1'b1;
    do begin
      @(posedge clk_i);
      cycles++;
      check_timeout(cycles, WAIT_LIMIT, "the AW and W handshake");
    end while (!cfg_rsp_o.aw_ready);
    // AW and W are accepted together
    check_value("cfg_rsp_o.w_ready", cfg_rsp_o.w_ready, 1'b1);
    cfg_req_i.aw_valid <= 1'b0;
    cfg_req_i.w_valid <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      check_timeout(cycles, WAIT_LIMIT, "the write response");
    end while (!cfg_rsp_o.b_valid);
    check_value("cfg_rsp_o.b_resp", cfg_rsp_o.b_resp, exp_resp);
  endtask

  task automatic cfg_read(input lite_addr_t offset, input lite_data_t exp_data);
    int unsigned cycles;
    cycles = 0;
    cfg_req_i.ar_valid <= 1'b1;
    cfg_req_i.ar_addr <= offset;
    cfg_req_i.r_ready <= 1'b1;
    do begin
      @(posedge clk_i);
      cycles++;
      check_timeout(cycles, WAIT_LIMIT, "the configuration AR handshake");
    end while (!cfg_rsp_o.ar_ready);
    cfg_req_i.ar_valid <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      check_timeout(cycles, WAIT_LIMIT, "the read response");
    end while (!cfg_rsp_o.r_valid);
    check_value("cfg_rsp_o.r_data", cfg_rsp_o.r_data, exp_data);
    check_value("cfg_rsp_o.r_resp", cfg_rsp_o.r_resp,
                (offset == REG_LEN_LIMIT) ? RESP_OKAY : RESP_SLVERR);
  endtask

  // -------------------------------------------------------------------
  // Read bursts: upstream master, downstream memory and upstream checker
  // -------------------------------------------------------------------
  task automatic run_group();
    int unsigned sent;
    int unsigned cycles;
    int unsigned dn_beat;
    int unsigned up_beat;
    logic ar_vld;
    logic r_vld;
    piece_t exp;
    r_chan_t beat;
    ar_chan_t req;
    sent = 0;
    cycles = 0;
    dn_beat = 0;
    up_beat = 0;
    ar_vld = 1'b0;
    r_vld = 1'b0;
    while (sent < req_q.size() || exp_q.size() != 0 || dn_q.size() != 0
           || up_q.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      check_timeout(cycles, GROUP_LIMIT, "a group of read bursts to complete");
      if (ar_vld && s_ar_ready_o) begin
        up_q.push_back(req_q[sent]);
        sent++;
        ar_vld = 1'b0;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Downstream piece at 0x%h is not listed in the trace", m_ar_o.addr);
          end_with_failure();
        end
        exp = exp_q.pop_front();
        check_value("m_ar_o.addr", m_ar_o.addr, exp.addr);
        check_value("m_ar_o.len", m_ar_o.len, exp.len);
        check_value("m_ar_o.id", m_ar_o.id, req_q[exp.req].id);
        check_value("m_ar_o.size", m_ar_o.size, req_q[exp.req].size);
        check_value("m_ar_o.burst", m_ar_o.burst, req_q[exp.req].burst);
        dn_q.push_back(m_ar_o);
      end
      // Memory side of an R beat
      if (m_r_valid_i && m_r_ready_o) begin
        dn_beat++;
        if (dn_beat > dn_q[0].len) begin
          void'(dn_q.pop_front());
          dn_beat = 0;
        end
        r_vld = 1'b0;
      end
      // Upstream side of the same beat
      if (s_r_valid_o && s_r_ready_i) begin
        assert (up_q.size() != 0) else begin
          $display("Upstream R beat arrived with no burst outstanding");
          end_with_failure();
        end
        req = up_q[0];
        check_value("s_r_o.id", s_r_o.id, req.id);
        check_value("s_r_o.data", s_r_o.data, beat_address(req, up_beat));
        check_value("s_r_o.resp", s_r_o.resp, AXI_OKAY);
        check_value("s_r_o.last", s_r_o.last, up_beat == req.len);
        up_beat++;
        if (up_beat > req.len) begin
          void'(up_q.pop_front());
          up_beat = 0;
        end
      end
      if (!ar_vld && sent < req_q.size() && random_active()) begin
        ar_vld = 1'b1;
        s_ar_i <= req_q[sent];
      end
      if (!r_vld && dn_q.size() != 0 && random_active()) begin
        r_vld = 1'b1;
        beat.id = dn_q[0].id;
        beat.data = beat_address(dn_q[0], dn_beat);
        beat.resp = AXI_OKAY;
        beat.last = (dn_beat == dn_q[0].len);
        m_r_i <= beat;
      end
      s_ar_valid_i <= ar_vld;
      m_r_valid_i <= r_vld;
      m_ar_ready_i <= random_active();
      s_r_ready_i <= random_active();
    end
    req_q.delete();
  endtask

  task automatic check_trace_fields(input int n, input int expected, input string line);
    assert (n == expected) else begin
      $display("Malformed trace line: %s", line);
      end_with_failure();
    end
  endtask

  // Consecutive A lines form one group of bursts issued back to back
  task automatic run_trace();
    int fd;
    int n;
    string line;
    logic [31:0] f1, f2, f3, f4, f5;
    piece_t pc;
    ar_chan_t ar;
    fd = $fopen(TRACE_FILE, "r");
    assert (fd != 0) else begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      end_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 3 || line[0] == "#") begin
        continue;
      end
      case (line[0])
        "C": begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", f1, f2, f3);
          check_trace_fields(n, 3, line);
          run_group();
          cfg_write(lite_addr_t'(f1), f2, lite_resp_t'(f3));
        end
        "R": begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f1, f2);
          check_trace_fields(n, 2, line);
          run_group();
          cfg_read(lite_addr_t'(f1), f2);
        end
        "A": begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h", f1, f2, f3, f4, f5);
          check_trace_fields(n, 5, line);
          ar.id = id_t'(f1);
          ar.addr = addr_t'(f2);
          ar.len = len_t'(f3);
          ar.size = size_t'(f4);
          ar.burst = burst_t'(f5);
          req_q.push_back(ar);
        end
        "P": begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f1, f2);
          check_trace_fields(n, 2, line);
          check_trace_fields(req_q.size() == 0 ? 0 : 1, 1, line);
          pc.addr = addr_t'(f1);
          pc.len = len_t'(f2);
          pc.req = 8'(req_q.size() - 1);
          exp_q.push_back(pc);
        end
        default: begin
          check_trace_fields(0, 1, line);
        end
      endcase
    end
    $fclose(fd);
    run_group();
  endtask

  initial begin
    void'($urandom(SEED));
    error_count = 0;
    arst_n_i = 1'b0;
    cfg_req_i = '0;
    s_ar_i = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_i = '0;
    m_r_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    run_trace();
    repeat (4) @(posedge clk_i);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb/splitter_asserts.sv ====
`timescale 1ns/1ps

module splitter_asserts
  import axi_rd_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input len_t     len_limit_i,
  input ar_chan_t m_ar_o,
  input logic     m_ar_valid_o,
  input logic     m_ar_ready_i
);

  // No downstream piece is longer than the programmed limit
  len_within_limit: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_o |-> (m_ar_o.len <= len_limit_i)
  ) else $error("downstream AR len 0x%h above limit 0x%h", m_ar_o.len, len_limit_i);

  // A stalled piece stays valid with the same payload
  ar_held_on_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_o))
  ) else $error("downstream AR changed while stalled");

endmodule

bind ar_burst_splitter splitter_asserts u_splitter_asserts (.*);

// ==== source/axi_burst_splitter_top.sv ====
`timescale 1ns/1ps
`include "axi_burst_cfg.svh"

module axi_burst_splitter_top
  import axi_rd_pkg::*;
  import cfg_lite_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Configuration port
  input  lite_req_t cfg_req_i,
  output lite_rsp_t cfg_rsp_o,
  // Upstream read port
  input  ar_chan_t  s_ar_i,
  input  logic      s_ar_valid_i,
  output logic      s_ar_ready_o,
  output r_chan_t   s_r_o,
  output logic      s_r_valid_o,
  input  logic      s_r_ready_i,
  // Downstream read port
  output ar_chan_t  m_ar_o,
  output logic      m_ar_valid_o,
  input  logic      m_ar_ready_i,
  input  r_chan_t   m_r_i,
  input  logic      m_r_valid_i,
  output logic      m_r_ready_o
);

  len_t len_limit;
  logic alloc_valid;
  beats_t alloc_beats;
  logic alloc_ready;

  axi_burst_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_rsp_o   (cfg_rsp_o),
    .len_limit_o (len_limit)
  );

  ar_burst_splitter u_ar_split (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .len_limit_i   (len_limit),
    .s_ar_i        (s_ar_i),
    .s_ar_valid_i  (s_ar_valid_i),
    .s_ar_ready_o  (s_ar_ready_o),
    .m_ar_o        (m_ar_o),
    .m_ar_valid_o  (m_ar_valid_o),
    .m_ar_ready_i  (m_ar_ready_i),
    .alloc_valid_o (alloc_valid),
    .alloc_beats_o (alloc_beats),
    .alloc_ready_i (alloc_ready)
  );

  read_last_restore #(
    .MAX_TXNS (`MAX_READ_TXNS)
  ) u_r_last (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .len_limit_i   (len_limit),
    .alloc_valid_i (alloc_valid),
    .alloc_beats_i (alloc_beats),
    .alloc_ready_o (alloc_ready),
    .m_r_i         (m_r_i),
    .m_r_valid_i   (m_r_valid_i),
    .m_r_ready_o   (m_r_ready_o),
    .s_r_o         (s_r_o),
    .s_r_valid_o   (s_r_valid_o),
    .s_r_ready_i   (s_r_ready_i)
  );

endmodule

// ==== splitter/read_last_restore.sv ====
`timescale 1ns/1ps

module read_last_restore
  import axi_rd_pkg::*;
#(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  len_t    len_limit_i,
  // Beat counts of accepted upstream bursts, in AR order
  input  logic    alloc_valid_i,
  input  beats_t  alloc_beats_i,
  output logic    alloc_ready_o,
  // Downstream R
  input  r_chan_t m_r_i,
  input  logic    m_r_valid_i,
  output logic    m_r_ready_o,
  // Upstream R
  output r_chan_t s_r_o,
  output logic    s_r_valid_o,
  input  logic    s_r_ready_i
);

  localparam int unsigned PTR_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0] occ_t;

  beats_t cnt_q [MAX_TXNS];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  occ_t occ_q;

  beats_t max_beats;
  beats_t head_beats;
  logic head_final;
  logic last_fire;
  logic push;
  logic pop;

  assign max_beats = {1'b0, len_limit_i} + 9'd1;
  assign head_beats = cnt_q[rd_ptr_q];
  // Head burst ends with the piece now returning
  assign head_final = (head_beats <= max_beats);

  // -------------------------------------------------------------------
  // R path, no storage
  // -------------------------------------------------------------------
  always_comb begin
    s_r_o = m_r_i;
    s_r_o.last = m_r_i.last & head_final;
  end

  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;

  assign last_fire = m_r_valid_i & s_r_ready_i & m_r_i.last;
  assign pop = last_fire & head_final;
  assign alloc_ready_o = (occ_q != occ_t'(MAX_TXNS));
  assign push = alloc_valid_i & alloc_ready_o;

  // -------------------------------------------------------------------
  // Counter FIFO
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      occ_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MAX_TXNS - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MAX_TXNS - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      occ_q <= occ_q + occ_t'(push) - occ_t'(pop);
    end
  end

  // A piece that is not the last one takes a full limit off the head
  always_ff @(posedge clk_i) begin
    if (push) begin
      cnt_q[wr_ptr_q] <= alloc_beats_i;
    end
    if (last_fire && !head_final) begin
      cnt_q[rd_ptr_q] <= head_beats - max_beats;
    end
  end

endmodule

// ==== splitter/ar_burst_splitter.sv ====
`timescale 1ns/1ps

module ar_burst_splitter
  import axi_rd_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  len_t     len_limit_i,
  // Upstream AR
  input  ar_chan_t s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  // Downstream AR
  output ar_chan_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  // Beat count handed to the R side
  output logic     alloc_valid_o,
  output beats_t   alloc_beats_o,
  input  logic     alloc_ready_i
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e state_q, state_d;
  ar_chan_t ar_q, ar_d;
  // Beats still to be requested downstream
  beats_t beats_q, beats_d;

  beats_t max_beats;
  beats_t s_beats;
  logic final_piece;

  // Next piece address: align to the beat size, then skip the beats already asked for
  function automatic addr_t step_addr(ar_chan_t ar, beats_t step);
    addr_t aligned;
    aligned = ar.addr & ~((addr_t'(1) << ar.size) - addr_t'(1));
    if (ar.burst == BURST_INCR) begin
      return aligned + (addr_t'(step) << ar.size);
    end
    return ar.addr;
  endfunction

  assign max_beats = {1'b0, len_limit_i} + 9'd1;
  assign s_beats = {1'b0, s_ar_i.len} + 9'd1;
  assign final_piece = (beats_q <= max_beats);

  assign alloc_beats_o = s_beats;
  assign alloc_valid_o = s_ar_valid_i & s_ar_ready_o;

  always_comb begin
    state_d = state_q;
    ar_d = ar_q;
    beats_d = beats_q;
    m_ar_o = s_ar_i;
    m_ar_valid_o = 1'b0;
    s_ar_ready_o = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        m_ar_valid_o = s_ar_valid_i & alloc_ready_i;
        if (s_ar_i.len <= len_limit_i) begin
          // Short enough, pass straight through
          s_ar_ready_o = m_ar_ready_i & alloc_ready_i;
        end else begin
          // Take the burst now and offer its first piece at once
          m_ar_o.len = len_limit_i;
          s_ar_ready_o = alloc_ready_i;
          if (s_ar_valid_i && alloc_ready_i) begin
            state_d = ST_BUSY;
            ar_d = s_ar_i;
            beats_d = s_beats;
            if (m_ar_ready_i) begin
              beats_d = s_beats - max_beats;
              ar_d.addr = step_addr(s_ar_i, max_beats);
            end
          end
        end
      end
      ST_BUSY: begin
        m_ar_o = ar_q;
        m_ar_valid_o = 1'b1;
        m_ar_o.len = final_piece ? len_t'(beats_q - 9'd1) : len_limit_i;
        if (m_ar_ready_i) begin
          if (final_piece) begin
            state_d = ST_IDLE;
          end else begin
            beats_d = beats_q - max_beats;
            ar_d.addr = step_addr(ar_q, max_beats);
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured burst, only meaningful while busy
  always_ff @(posedge clk_i) begin
    ar_q <= ar_d;
    beats_q <= beats_d;
  end

endmodule

// ==== source/axi_burst_cfg_regs.sv ====
`timescale 1ns/1ps

module axi_burst_cfg_regs
  import axi_rd_pkg::*;
  import cfg_lite_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  lite_req_t cfg_req_i,
  output lite_rsp_t cfg_rsp_o,
  output len_t      len_limit_o
);

  logic wr_fire;
  logic rd_fire;
  logic wr_hit;
  logic rd_hit;

  logic b_pending_q;
  logic r_pending_q;
  lite_resp_t b_resp_q;
  lite_resp_t r_resp_q;
  lite_data_t r_data_q;
  len_t len_limit_q;

  // AW and W are taken together, once the previous B has left
  assign wr_fire = cfg_req_i.aw_valid & cfg_req_i.w_valid & ~b_pending_q;
  assign rd_fire = cfg_req_i.ar_valid & ~r_pending_q;

  assign wr_hit = (cfg_req_i.aw_addr == REG_LEN_LIMIT);
  assign rd_hit = (cfg_req_i.ar_addr == REG_LEN_LIMIT);

  // -------------------------------------------------------------------
  // Control state
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_pending_q <= 1'b0;
      r_pending_q <= 1'b0;
      len_limit_q <= '0;
    end else begin
      if (wr_fire) begin
        b_pending_q <= 1'b1;
      end else if (cfg_req_i.b_ready) begin
        b_pending_q <= 1'b0;
      end
      if (rd_fire) begin
        r_pending_q <= 1'b1;
      end else if (cfg_req_i.r_ready) begin
        r_pending_q <= 1'b0;
      end
      // Only the low byte is kept, the rest reads back as zero
      if (wr_fire && wr_hit) begin
        len_limit_q <= cfg_req_i.w_data[7:0];
      end
    end
  end

  // Response payloads, captured with the request
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_data_q <= rd_hit ? lite_data_t'(len_limit_q) : '0;
      r_resp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    cfg_rsp_o.aw_ready = wr_fire;
    cfg_rsp_o.w_ready = wr_fire;
    cfg_rsp_o.b_valid = b_pending_q;
    cfg_rsp_o.b_resp = b_resp_q;
    cfg_rsp_o.ar_ready = ~r_pending_q;
    cfg_rsp_o.r_valid = r_pending_q;
    cfg_rsp_o.r_data = r_data_q;
    cfg_rsp_o.r_resp = r_resp_q;
  end

  assign len_limit_o = len_limit_q;

endmodule

// ==== common/cfg_lite_pkg.sv ====
`include "axi_burst_cfg.svh"

package cfg_lite_pkg;

  typedef logic [`LITE_ADDR_W-1:0] lite_addr_t;
  typedef logic [`LITE_DATA_W-1:0] lite_data_t;
  typedef logic [1:0] lite_resp_t;

  localparam lite_resp_t RESP_OKAY = 2'b00;
  localparam lite_resp_t RESP_SLVERR = 2'b10;

  // Register map
  localparam lite_addr_t REG_LEN_LIMIT = '0;

  // Master to slave signals of the configuration port
  typedef struct packed {
    logic aw_valid;
    lite_addr_t aw_addr;
    logic w_valid;
    lite_data_t w_data;
    logic b_ready;
    logic ar_valid;
    lite_addr_t ar_addr;
    logic r_ready;
  } lite_req_t;

  // Slave to master signals
  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic b_valid;
    lite_resp_t b_resp;
    logic ar_ready;
    logic r_valid;
    lite_data_t r_data;
    lite_resp_t r_resp;
  } lite_rsp_t;

endpackage

// ==== common/axi_rd_pkg.sv ====
`include "axi_burst_cfg.svh"

package axi_rd_pkg;

  // -------------------------------------------------------------------
  // Field types of the AXI4 read channels
  // -------------------------------------------------------------------
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`AXI_ID_W-1:0] id_t;

  // Burst length as on the bus, one less than the beats
  typedef logic [7:0] len_t;
  // Beat count, one bit wider to hold 256
  typedef logic [8:0] beats_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // Only FIXED and INCR are handled by the splitter
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR = 2'b01;

  // -------------------------------------------------------------------
  // Channel payloads
  // -------------------------------------------------------------------
  typedef struct packed {
    id_t id;
    addr_t addr;
    len_t len;
    size_t size;
    burst_t burst;
  } ar_chan_t;

  typedef struct packed {
    id_t id;
    data_t data;
    resp_t resp;
    logic last;
  } r_chan_t;

endpackage

// ==== common/axi_burst_cfg.svh ====
`ifndef AXI_BURST_CFG_SVH
`define AXI_BURST_CFG_SVH

// AXI4 data path widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4

// Upstream read bursts that may be outstanding at once
`define MAX_READ_TXNS 4

// AXI4-Lite configuration port widths
`define LITE_ADDR_W 4
`define LITE_DATA_W 32

`endif
